/* logic/vdp_pkg.sv */
package vdp_pkg;

    // ------------------------------------------------------------------------
    // display timing, 640x480 at 25 MHz pixel clock

    localparam int h_display = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_display + h_front + h_sync + h_back;  // 800

    localparam int v_display = 480;
    localparam int v_bottom  = 10;
    localparam int v_sync    = 2;
    localparam int v_top     = 33;
    localparam int v_total   = v_display + v_bottom + v_sync + v_top;  // 525

    localparam int hpos_width = 10;
    localparam int vpos_width = 10;

    localparam int n_vdp_pipe = 2;  // position to color latency

    // ------------------------------------------------------------------------
    // sprites and color

    localparam int n_sprites          = 8;
    localparam int sprite_size        = 8;
    localparam int rgb_width          = 3;
    localparam int sprite_index_width = 3;
    localparam int row_index_width    = 3;

    // ------------------------------------------------------------------------
    // bus address map

    localparam int addr_sprite_bit = 11;  // set for sprite space
    localparam int addr_xy_bit     = 10;  // 1 position, 0 bitmap row
    localparam int addr_sprite_lsb = 5;   // sprite index in 7:5
    localparam int addr_row_lsb    = 2;   // row index in 4:2

    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;
    localparam logic [2:0] hsize_word    = 3'b010;

    // ------------------------------------------------------------------------
    // write data word, decoded by address bit 10

    typedef struct packed
    {
        logic [5:0]            pad_y;
        logic [vpos_width-1:0] y;      // bits 25:16
        logic [5:0]            pad_x;
        logic [hpos_width-1:0] x;      // bits 9:0
    } vdp_xy_t;

    typedef struct packed
    {
        logic [7:0]                           pad;
        logic [sprite_size-1:0][rgb_width-1:0] pix;  // pix[0] is leftmost
    } vdp_row_t;

    typedef union packed
    {
        vdp_xy_t  xy;
        vdp_row_t row;
    } vdp_wr_word_t;

    // one write command, valid in the AHB data phase
    typedef struct packed
    {
        logic                          xy_we;
        logic                          row_we;
        logic [sprite_index_width-1:0] sprite;
        logic [row_index_width-1:0]    row;
        vdp_wr_word_t                  data;
    } vdp_sprite_wr_t;

endpackage

/* logic/vdp_hvsync.sv */
`timescale 1ns/1ps

module vdp_hvsync
(
    input  logic                            clk,
    input  logic                            reset,
    output logic [vdp_pkg::hpos_width-1:0] hpos,
    output logic [vdp_pkg::vpos_width-1:0] vpos,
    output logic                            display_on,
    output logic                            hsync,
    output logic                            vsync
);
    import vdp_pkg::*;

    localparam int h_sync_start = h_display + h_front;  // 656
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = v_display + v_bottom;  // 490
    localparam int v_sync_end   = v_sync_start + v_sync;

    logic                  h_last;
    logic                  v_last;
    logic                  hsync_raw;
    logic                  vsync_raw;
    logic [n_vdp_pipe-1:0] hsync_pipe;
    logic [n_vdp_pipe-1:0] vsync_pipe;

    // ------------------------------------------------------------------------
    // position counters

    assign h_last = (hpos == hpos_width'(h_total - 1));
    assign v_last = (vpos == vpos_width'(v_total - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hpos <= '0;
            vpos <= '0;
        end
        else
        begin
            hpos <= h_last ? '0 : hpos + 1'b1;
            if (h_last)
                vpos <= v_last ? '0 : vpos + 1'b1;
        end
    end

    assign display_on = (hpos < hpos_width'(h_display)) && (vpos < vpos_width'(v_display));

    // ------------------------------------------------------------------------
    // sync pulses, active low, delayed to line up with the color output

    assign hsync_raw = !((hpos >= hpos_width'(h_sync_start))
                      && (hpos <  hpos_width'(h_sync_end)));
    assign vsync_raw = !((vpos >= vpos_width'(v_sync_start))
                      && (vpos <  vpos_width'(v_sync_end)));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hsync_pipe <= '1;  // inactive
            vsync_pipe <= '1;
        end
        else
        begin
            hsync_pipe <= {hsync_pipe[n_vdp_pipe-2:0], hsync_raw};
            vsync_pipe <= {vsync_pipe[n_vdp_pipe-2:0], vsync_raw};
        end
    end

    assign hsync = hsync_pipe[n_vdp_pipe-1];
    assign vsync = vsync_pipe[n_vdp_pipe-1];

endmodule

/* logic/vdp_sprite.sv */
`timescale 1ns/1ps

module vdp_sprite
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [vdp_pkg::hpos_width-1:0] hpos,
    input  logic [vdp_pkg::vpos_width-1:0] vpos,
    input  vdp_pkg::vdp_sprite_wr_t         wr,
    input  logic                            select,  // this sprite is addressed
    output logic                            rgb_en,
    output logic [vdp_pkg::rgb_width-1:0]  rgb
);
    import vdp_pkg::*;

    logic [hpos_width-1:0]                 x;
    logic [vpos_width-1:0]                 y;
    logic [sprite_size-1:0][rgb_width-1:0] rows [sprite_size];

    logic [hpos_width:0]  dx;  // extra bit so a left-of-sprite pixel stays large
    logic [vpos_width:0]  dy;
    logic                 in_box;
    logic [rgb_width-1:0] code;

    // ------------------------------------------------------------------------
    // position and bitmap registers

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x <= '0;
            y <= '0;
        end
        else if (select && wr.xy_we)
        begin
            x <= wr.data.xy.x;
            y <= wr.data.xy.y;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int r = 0; r < sprite_size; r++)
                rows[r] <= '0;  // all transparent
        end
        else if (select && wr.row_we)
        begin
            rows[wr.row] <= wr.data.row.pix;
        end
    end

    // ------------------------------------------------------------------------
    // hit test and pixel lookup

    assign dx = {1'b0, hpos} - {1'b0, x};
    assign dy = {1'b0, vpos} - {1'b0, y};

    assign in_box = (dx < (hpos_width + 1)'(sprite_size))
                 && (dy < (vpos_width + 1)'(sprite_size));

    assign code = rows[dy[row_index_width-1:0]][dx[row_index_width-1:0]];

    // first pipeline stage
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rgb_en <= 1'b0;
            rgb    <= '0;
        end
        else
        begin
            rgb_en <= in_box && (code != '0);  // code 0 is see-through
            rgb    <= code;
        end
    end

endmodule

/* logic/vdp_ahb_write_port.sv */
`timescale 1ns/1ps

module vdp_ahb_write_port
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             haddr,
    input  logic [1:0]              htrans,
    input  logic [2:0]              hsize,
    input  logic                    hwrite,
    input  logic                    hsel,
    input  logic                    hready,
    input  logic [31:0]             hwdata,
    output vdp_pkg::vdp_sprite_wr_t wr,
    output logic [31:0]             hrdata,
    output logic                    hreadyout,
    output logic                    hresp
);
    import vdp_pkg::*;

    logic                               accept;
    logic                               write_q;
    logic [addr_sprite_bit:addr_row_lsb] addr_q;
    logic                               sprite_space;

    // ------------------------------------------------------------------------
    // address phase

    assign accept = hsel && hready && hwrite
                 && (htrans == htrans_nonseq || htrans == htrans_seq)  // seq taken as nonseq
                 && (hsize == hsize_word);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            write_q <= 1'b0;
        else
            write_q <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= haddr[addr_sprite_bit:addr_row_lsb];
    end

    // ------------------------------------------------------------------------
    // data phase decode, hwdata is valid now

    assign sprite_space = write_q && addr_q[addr_sprite_bit];

    always_comb
    begin
        wr.xy_we  = sprite_space &&  addr_q[addr_xy_bit];
        wr.row_we = sprite_space && !addr_q[addr_xy_bit];
        wr.sprite = addr_q[addr_sprite_lsb +: sprite_index_width];
        wr.row    = addr_q[addr_row_lsb +: row_index_width];
        wr.data   = hwdata;
    end

    // write-only slave, never stalls
    assign hrdata    = '0;
    assign hreadyout = 1'b1;
    assign hresp     = 1'b0;  // okay

endmodule

/* logic/vdp_priority_mixer.sv */
`timescale 1ns/1ps

module vdp_priority_mixer
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           display_on,
    input  logic                           hpos_5,
    input  logic                           vpos_5,
    input  logic [vdp_pkg::n_sprites-1:0] sprite_en,
    input  logic [vdp_pkg::rgb_width-1:0] sprite_rgb [vdp_pkg::n_sprites],
    output logic [vdp_pkg::rgb_width-1:0] rgb
);
    import vdp_pkg::*;

    logic display_on_d;  // aligned with sprite outputs
    logic hpos_5_d;
    logic vpos_5_d;

    logic                 en_l1  [4];
    logic [rgb_width-1:0] rgb_l1 [4];
    logic                 en_l2  [2];
    logic [rgb_width-1:0] rgb_l2 [2];
    logic                 any_en;
    logic [rgb_width-1:0] sel_rgb;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            display_on_d <= 1'b0;
            hpos_5_d     <= 1'b0;
            vpos_5_d     <= 1'b0;
        end
        else
        begin
            display_on_d <= display_on;
            hpos_5_d     <= hpos_5;
            vpos_5_d     <= vpos_5;
        end
    end

    // ------------------------------------------------------------------------
    // balanced priority tree, upper index wins each pair

    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            en_l1[j]  = sprite_en[2*j+1] || sprite_en[2*j];
            rgb_l1[j] = sprite_en[2*j+1] ? sprite_rgb[2*j+1] : sprite_rgb[2*j];
        end
        for (int j = 0; j < 2; j++)
        begin
            en_l2[j]  = en_l1[2*j+1] || en_l1[2*j];
            rgb_l2[j] = en_l1[2*j+1] ? rgb_l1[2*j+1] : rgb_l1[2*j];
        end
        any_en  = en_l2[1] || en_l2[0];
        sel_rgb = en_l2[1] ? rgb_l2[1] : rgb_l2[0];
    end

    // second pipeline stage
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rgb <= '0;
        else if (!display_on_d)
            rgb <= '0;  // black in blanking
        else if (any_en)
            rgb <= sel_rgb;
        else
            rgb <= {1'b0, hpos_5_d, vpos_5_d};  // checkerboard
    end

endmodule

/* logic/vdp.sv */
`timescale 1ns/1ps

module vdp
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    haddr,
    input  logic [1:0]                     htrans,
    input  logic [2:0]                     hsize,
    input  logic [2:0]                     hburst,  // beats handled one by one
    input  logic                           hwrite,
    input  logic                           hsel,
    input  logic                           hready,
    input  logic [31:0]                    hwdata,
    output logic [31:0]                    hrdata,
    output logic                           hreadyout,
    output logic                           hresp,
    output logic                           vga_hsync,
    output logic                           vga_vsync,
    output logic [vdp_pkg::rgb_width-1:0] vga_rgb
);
    import vdp_pkg::*;

    vdp_sprite_wr_t        wr;
    logic [n_sprites-1:0]  sprite_sel;
    logic [hpos_width-1:0] hpos;
    logic [vpos_width-1:0] vpos;
    logic                  display_on;
    logic [n_sprites-1:0]  sprite_en;
    logic [rgb_width-1:0]  sprite_rgb [n_sprites];

    vdp_ahb_write_port i_write_port
    (
        .clk       (clk),
        .reset     (reset),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hsel      (hsel),
        .hready    (hready),
        .hwdata    (hwdata),
        .wr        (wr),
        .hrdata    (hrdata),
        .hreadyout (hreadyout),
        .hresp     (hresp)
    );

    vdp_hvsync i_hvsync
    (
        .clk        (clk),
        .reset      (reset),
        .hpos       (hpos),
        .vpos       (vpos),
        .display_on (display_on),
        .hsync      (vga_hsync),
        .vsync      (vga_vsync)
    );

    // ------------------------------------------------------------------------
    // sprite bank

    assign sprite_sel = n_sprites'(1) << wr.sprite;  // one-hot of the addressed sprite

    for (genvar i = 0; i < n_sprites; i++)
    begin : gen_sprite
        vdp_sprite i_sprite
        (
            .clk    (clk),
            .reset  (reset),
            .hpos   (hpos),
            .vpos   (vpos),
            .wr     (wr),
            .select (sprite_sel[i]),
            .rgb_en (sprite_en[i]),
            .rgb    (sprite_rgb[i])
        );
    end

    vdp_priority_mixer i_mixer
    (
        .clk        (clk),
        .reset      (reset),
        .display_on (display_on),
        .hpos_5     (hpos[5]),  // 32 pixel checker squares
        .vpos_5     (vpos[5]),
        .sprite_en  (sprite_en),
        .sprite_rgb (sprite_rgb),
        .rgb        (vga_rgb)
    );

endmodule

/* dv/vdp_properties.sv */
`timescale 1ns/1ps

module vdp_properties
(
    input logic                           clk,
    input logic                           reset,
    input logic                           hreadyout,
    input logic                           hresp,
    input logic                           display_on,
    input logic                           vga_hsync,
    input logic [vdp_pkg::rgb_width-1:0] vga_rgb
);
    import vdp_pkg::*;

    int   hsync_low_len;  // consecutive low samples of vga_hsync
    int   assert_failures = 0;
    logic display_q1;
    logic display_q2;     // display_on aligned with vga_rgb

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hsync_low_len <= 0;
            display_q1    <= 1'b0;
            display_q2    <= 1'b0;
        end
        else
        begin
            hsync_low_len <= vga_hsync ? 0 : hsync_low_len + 1;
            display_q1    <= display_on;
            display_q2    <= display_q1;
        end
    end

    bus_okay: assert property (@(posedge clk) disable iff (reset) hreadyout && !hresp)
        else
        begin
            assert_failures++;
            $error("bus response is not ready and okay");
        end

    hsync_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_hsync) |-> hsync_low_len == h_sync)
        else
        begin
            assert_failures++;
            $error("vga_hsync low pulse lasted %0d cycles", hsync_low_len);
        end

    blank_black: assert property (@(posedge clk) disable iff (reset)
        !display_q2 |-> vga_rgb == '0)
        else
        begin
            assert_failures++;
            $error("vga_rgb is %0d outside the display area", vga_rgb);
        end

endmodule

bind vdp vdp_properties i_props
(
    .clk        (clk),
    .reset      (reset),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .display_on (display_on),
    .vga_hsync  (vga_hsync),
    .vga_rgb    (vga_rgb)
);

/* dv/vdp_checker.sv */
`timescale 1ns/1ps

module vdp_checker
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    haddr,
    input  logic [1:0]                     htrans,
    input  logic [2:0]                     hsize,
    input  logic                           hwrite,
    input  logic                           hsel,
    input  logic                           hready,
    input  logic [31:0]                    hwdata,
    input  logic [31:0]                    hrdata,
    input  logic                           hreadyout,
    input  logic                           hresp,
    input  logic                           vga_hsync,
    input  logic                           vga_vsync,
    input  logic [vdp_pkg::rgb_width-1:0] vga_rgb,
    output logic                           in_vblank,
    output int                             pixel_errors,
    output int                             sync_errors,
    output int                             bus_errors
);
    import vdp_pkg::*;

    int                   edges = 0;  // rising edges since reset release
    int                   sx [n_sprites];
    int                   sy [n_sprites];
    logic [rgb_width-1:0] bitmap [n_sprites][sprite_size][sprite_size];  // sprite, row, column
    logic                 pending;    // accepted address phase
    logic [31:0]          addr_q;

    assign in_vblank = ((edges / h_total) % v_total) >= v_display;

    // ------------------------------------------------------------------------
    // sprite model fed by the bus

    task automatic apply_write(input logic [31:0] a, input logic [31:0] d);
        int s;
        int r;
        s = int'(a[addr_sprite_lsb +: 3]);
        r = int'(a[addr_row_lsb +: 3]);
        if (a[addr_xy_bit])
        begin
            sx[s] = int'(d[9:0]);
            sy[s] = int'(d[25:16]);
        end
        else
        begin
            for (int c = 0; c < sprite_size; c++)
                bitmap[s][r][c] = d[3*c +: 3];  // column 0 in the low bits
        end
    endtask

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            edges   = 0;
            pending = 1'b0;
            addr_q  = '0;
            for (int s = 0; s < n_sprites; s++)
            begin
                sx[s] = 0;
                sy[s] = 0;
                for (int r = 0; r < sprite_size; r++)
                    for (int c = 0; c < sprite_size; c++)
                        bitmap[s][r][c] = '0;
            end
        end
        else
        begin
            edges = edges + 1;
            if (pending && addr_q[addr_sprite_bit])
                apply_write(addr_q, hwdata);  // data phase
            pending = hsel && hready && hwrite && hsize == hsize_word
                   && (htrans == htrans_nonseq || htrans == htrans_seq);
            addr_q  = haddr;
        end
    end

    // ------------------------------------------------------------------------
    // expected picture

    function automatic logic [rgb_width-1:0] color_at(int x, int y);
        logic [rgb_width-1:0] c;
        int                   dx;
        int                   dy;
        if (x >= h_display || y >= v_display)
            return '0;
        c = {1'b0, x[5], y[5]};  // background squares
        for (int s = 0; s < n_sprites; s++)
        begin
            dx = x - sx[s];
            dy = y - sy[s];
            if (dx >= 0 && dx < sprite_size && dy >= 0 && dy < sprite_size)
            begin
                if (bitmap[s][dy][dx] != '0)
                    c = bitmap[s][dy][dx];  // later sprite overrides
            end
        end
        return c;
    endfunction

    task automatic show_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    always @(negedge clk)
    begin : compare
        int                   k;
        int                   x;
        int                   y;
        logic [rgb_width-1:0] exp_rgb;
        logic                 exp_hsync;
        logic                 exp_vsync;
        if (reset)
        begin
            pixel_errors = 0;
            sync_errors  = 0;
            bus_errors   = 0;
        end
        else
        begin
            k         = edges - n_vdp_pipe;  // counter value now on the outputs
            exp_rgb   = '0;
            exp_hsync = 1'b1;
            exp_vsync = 1'b1;
            if (k >= 0)
            begin
                x         = k % h_total;
                y         = (k / h_total) % v_total;
                exp_rgb   = color_at(x, y);
                exp_hsync = !(x >= h_display + h_front && x < h_display + h_front + h_sync);
                exp_vsync = !(y >= v_display + v_bottom && y < v_display + v_bottom + v_sync);
            end
            if (vga_rgb !== exp_rgb)
            begin
                pixel_errors++;
                show_mismatch("vga_rgb", 32'(exp_rgb), 32'(vga_rgb));
            end
            if (vga_hsync !== exp_hsync)
            begin
                sync_errors++;
                show_mismatch("vga_hsync", 32'(exp_hsync), 32'(vga_hsync));
            end
            if (vga_vsync !== exp_vsync)
            begin
                sync_errors++;
                show_mismatch("vga_vsync", 32'(exp_vsync), 32'(vga_vsync));
            end
            if (hrdata !== '0)
            begin
                bus_errors++;
                show_mismatch("hrdata", 32'h0, hrdata);
            end
            if (hreadyout !== 1'b1)
            begin
                bus_errors++;
                show_mismatch("hreadyout", 32'h1, 32'(hreadyout));
            end
            if (hresp !== 1'b0)
            begin
                bus_errors++;
                show_mismatch("hresp", 32'h0, 32'(hresp));
            end
        end
    end

endmodule

/* dv/vdp_tb.sv */
`timescale 1ns/1ps

module vdp_tb;
    import vdp_pkg::*;

    localparam int frame_cycles   = h_total * v_total;
    localparam int timeout_cycles = 4 * frame_cycles;  // 3 stimulus frames plus a display frame
    localparam int n_frames       = 3;
    localparam int n_transfers    = 40;

    logic                 clk = 1'b0;
    logic                 reset;
    logic [31:0]          haddr;
    logic [1:0]           htrans;
    logic [2:0]           hsize;
    logic [2:0]           hburst;
    logic                 hwrite;
    logic                 hsel;
    logic                 hready;
    logic [31:0]          hwdata;
    logic [31:0]          hrdata;
    logic                 hreadyout;
    logic                 hresp;
    logic                 vga_hsync;
    logic                 vga_vsync;
    logic [rgb_width-1:0] vga_rgb;

    logic in_vblank;  // from the checker's position model
    int   pixel_errors;
    int   sync_errors;
    int   bus_errors;
    int   assert_errors;
    int   cycles = 0;

    always #50 clk = ~clk;

    vdp dut (.*);

    vdp_checker i_checker (.*);

    // ------------------------------------------------------------------------
    // watchdog

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles)
        begin
            $display("timeout after %0d cycles, the stimulus never completed", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus

    task automatic wait_vblank();
        while (in_vblank)
            @(negedge clk);
        while (!in_vblank)
            @(negedge clk);
    endtask

    function automatic logic [31:0] position_word();
        logic [31:0] w;
        w = $urandom;  // padding stays random
        if ($urandom % 2 == 0)
        begin
            w[9:0]   = 10'(300 + $urandom % 24);  // cluster for overlaps
            w[25:16] = 10'(200 + $urandom % 24);
        end
        else
        begin
            w[9:0]   = 10'($urandom % 700);  // may cross the right edge
            w[25:16] = 10'($urandom % 500);
        end
        return w;
    endfunction

    function automatic logic [31:0] row_word();
        logic [31:0] w;
        w = $urandom;
        for (int i = 0; i < sprite_size; i++)
            w[3*i +: 3] = ($urandom % 2 == 0) ? 3'b000 : 3'($urandom);  // half transparent
        return w;
    endfunction

    task automatic random_transfer();
        int          kind;
        logic        xy;
        logic [31:0] data;
        kind = int'($urandom % 17);
        xy   = (kind < 6) ? 1'b1 : (kind < 11) ? 1'b0 : 1'($urandom);
        data = xy ? position_word() : row_word();
        haddr                  = $urandom;
        haddr[addr_sprite_bit] = 1'b1;
        haddr[addr_xy_bit]     = xy;
        haddr[1:0]             = 2'b00;
        htrans = ($urandom % 2 == 0) ? htrans_nonseq : htrans_seq;
        hsize  = hsize_word;
        hburst = 3'($urandom);
        hwrite = 1'b1;
        hsel   = 1'b1;
        hready = 1'b1;
        case (kind)
            11: htrans = 2'b00;                  // idle
            12: hsel = 1'b0;
            13: hwrite = 1'b0;                   // read
            14: hsize = 3'b000;                  // byte
            15: haddr[addr_sprite_bit] = 1'b0;   // outside sprite space
            16: hready = 1'b0;
            default: ;
        endcase
        @(negedge clk);
        hwdata = data;  // data phase
        htrans = 2'b00;
        hsel   = 1'b0;
        hwrite = 1'b0;
        hready = 1'b1;
        @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(13));
        reset  = 1'b1;
        haddr  = '0;
        htrans = 2'b00;
        hsize  = 3'b000;
        hburst = 3'b000;
        hwrite = 1'b0;
        hsel   = 1'b0;
        hready = 1'b1;
        hwdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int f = 0; f < n_frames; f++)
        begin
            wait_vblank();  // first frame shows only background
            repeat (n_transfers)
            begin
                random_transfer();
                repeat ($urandom % 3) @(negedge clk);
            end
        end
        wait_vblank();  // one whole frame with the final sprites
        assert_errors = dut.i_props.assert_failures;
        $display("errors: pixel %0d, sync %0d, bus %0d, assertion %0d",
                 pixel_errors, sync_errors, bus_errors, assert_errors);
        if (pixel_errors + sync_errors + bus_errors + assert_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* compile.f */
logic/vdp_pkg.sv
logic/vdp_hvsync.sv
logic/vdp_sprite.sv
logic/vdp_ahb_write_port.sv
logic/vdp_priority_mixer.sv
logic/vdp.sv
dv/vdp_properties.sv
dv/vdp_checker.sv
dv/vdp_tb.sv

/* run.sh */
#!/bin/sh
# build and run the vdp testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vdp_tb -f compile.f \
    -o vdp_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/vdp_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    && ! grep -q "Verification failed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
